// ==== umi_pkg.sv ====
// UMI packet definitions
package umi_pkg;

   // ################################################
   // Packet field widths
   // ################################################
   localparam int CW = 32;                      // Command
   localparam int AW = 64;                      // Address
   localparam int DW = 128;                     // Data
   localparam int PW = CW + AW + AW + DW;       // Full packet, 288 bits
   localparam int PB = PW / 8;                  // 36 bytes
   localparam int HDR_BYTES = (CW + AW + AW) / 8; // Cmd plus both addresses
   localparam int CMD_BYTES = CW / 8;

   // Command field positions
   localparam int OPCODE_LSB = 0;               // Bits 4..0
   localparam int SIZE_LSB = 5;                 // Bits 7..5
   localparam int LEN_LSB = 8;                  // Bits 15..8

   // ################################################
   // Opcodes
   // ################################################
   localparam logic [4:0] OP_INVALID = 5'h00;
   localparam logic [4:0] OP_REQ_READ = 5'h01;
   localparam logic [4:0] OP_REQ_WRITE = 5'h03;
   localparam logic [4:0] OP_REQ_POSTED = 5'h05;
   localparam logic [4:0] OP_REQ_RDMA = 5'h07;
   localparam logic [4:0] OP_REQ_ATOMIC = 5'h09;
   localparam logic [4:0] OP_REQ_USER0 = 5'h0B;
   localparam logic [4:0] OP_REQ_FUTURE0 = 5'h0D;
   localparam logic [4:0] OP_REQ_ERROR = 5'h0F;  // Size field 0
   localparam logic [4:0] OP_REQ_LINK = 5'h0F;   // Same opcode, size field 1
   localparam logic [4:0] OP_RESP_READ = 5'h02;
   localparam logic [4:0] OP_RESP_WRITE = 5'h04;
   localparam logic [4:0] OP_RESP_LINK = 5'h0E;

   // Low command byte of a link message
   localparam logic [7:0] LINK_LOW = {3'b001, OP_REQ_LINK};

   typedef logic [CW-1:0] umi_cmd_t;

endpackage

// ==== lumi_pkg.sv ====
// Link transmit definitions
package lumi_pkg;

   // ################################################
   // Phy line and credit widths
   // ################################################
   localparam int IOW = 64;                     // Phy line width
   localparam int IOB = IOW / 8;                // Max bytes per line
   localparam int CRDT_W = 16;
   localparam int LINES_W = 12;                 // Byte and line counts
   localparam int LOG_W = 2;                    // Line bytes = 1 << code

   // Credit message fields
   localparam logic [3:0] CH_REQ = 4'h0;
   localparam logic [3:0] CH_RESP = 4'h1;
   localparam logic [3:0] MSG_INIT = 4'h1;      // Local side still in init
   localparam logic [3:0] MSG_UPDT = 4'h2;

   // ################################################
   // Configuration registers
   // ################################################
   localparam int CFG_AW = 2;
   localparam int CFG_DW = 16;
   localparam logic [CFG_AW-1:0] CFG_CTRL = 2'd0;
   localparam logic [CFG_AW-1:0] CFG_INTRVL = 2'd1;

   // Control register bits
   localparam int CTRL_EN_BIT = 0;
   localparam int CTRL_CRDT_BIT = 1;
   localparam int CTRL_IOW_LSB = 2;             // Bits 3..2

   typedef logic [CRDT_W-1:0] crdt_t;
   typedef logic [umi_pkg::PB-1:0] mask_t;      // One bit per packet byte

endpackage

// ==== lumi_tx_cfg.sv ====
// Transmit configuration registers
`timescale 1ns/1ps

module lumi_tx_cfg
  (
   input  logic                         clk,
   input  logic                         nreset,
   input  logic                         cfg_req,
   input  logic [lumi_pkg::CFG_AW-1:0]  cfg_addr,
   input  logic [lumi_pkg::CFG_DW-1:0]  cfg_wdata,
   output logic                         cfg_ack,
   output logic                         tx_en,
   output logic                         crdt_en,
   output logic [lumi_pkg::LOG_W-1:0]   iowidth,
   output lumi_pkg::crdt_t              crdt_intrvl
   );

   logic cfg_wr;

   // One write per request phase, taken while ack is still low
   assign cfg_wr = cfg_req & ~cfg_ack;

   // Ack follows req one cycle later in both directions
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         cfg_ack <= 1'b0;
      else if (cfg_wr)
         cfg_ack <= 1'b1;
      else if (!cfg_req)
         cfg_ack <= 1'b0;                       // Host dropped req
   end

   // ################################################
   // Register file
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tx_en <= 1'b0;
         crdt_en <= 1'b0;
         iowidth <= '1;                         // Full 8 byte line
         crdt_intrvl <= '0;
      end
      else if (cfg_wr)
      begin
         case (cfg_addr)
            lumi_pkg::CFG_CTRL:
            begin
               tx_en <= cfg_wdata[lumi_pkg::CTRL_EN_BIT];
               crdt_en <= cfg_wdata[lumi_pkg::CTRL_CRDT_BIT];
               iowidth <= cfg_wdata[lumi_pkg::CTRL_IOW_LSB +: lumi_pkg::LOG_W];
            end
            lumi_pkg::CFG_INTRVL:
               crdt_intrvl <= cfg_wdata;
            default:
               ;                                // Unmapped, ack only
         endcase
      end
   end

   // Handshake order
   a_ack_needs_req: assert property (@(posedge clk) disable iff (!nreset)
      $rose(cfg_ack) |-> $past(cfg_req));

endmodule

// ==== lumi_tx_sizer.sv ====
// Packet size decoder
`timescale 1ns/1ps

module lumi_tx_sizer
  (
   input  umi_pkg::umi_cmd_t             cmd,
   input  logic [lumi_pkg::LOG_W-1:0]    iowidth,
   output lumi_pkg::mask_t               pkt_mask,
   output lumi_pkg::crdt_t               crdt_need
   );

   logic [4:0]                    opcode;
   logic [2:0]                    size;
   logic [7:0]                    len;
   logic [15:0]                   data_raw;
   logic [15:0]                   data_cap;
   logic [lumi_pkg::LINES_W-1:0]  pkt_bytes;
   logic [lumi_pkg::LINES_W-1:0]  pkt_lines;

   assign opcode = cmd[umi_pkg::OPCODE_LSB +: 5];
   assign size = cmd[umi_pkg::SIZE_LSB +: 3];
   assign len = cmd[umi_pkg::LEN_LSB +: 8];

   // Data bytes are (len+1) << size, never more than the data field
   assign data_raw = ({8'h00, len} + 16'd1) << size;
   assign data_cap = (data_raw > 16'(umi_pkg::DW / 8)) ? 16'(umi_pkg::DW / 8) : data_raw;

   // ################################################
   // Byte count per opcode class
   // ################################################
   always_comb
   begin
      case (opcode)
         umi_pkg::OP_INVALID,
         umi_pkg::OP_RESP_LINK:
            pkt_bytes = lumi_pkg::LINES_W'(umi_pkg::CMD_BYTES);
         umi_pkg::OP_REQ_ERROR:                 // Shared with link, split by size
            if (cmd[7:0] == umi_pkg::LINK_LOW)
               pkt_bytes = lumi_pkg::LINES_W'(umi_pkg::CMD_BYTES);
            else
               pkt_bytes = lumi_pkg::LINES_W'(umi_pkg::HDR_BYTES);
         umi_pkg::OP_REQ_READ,
         umi_pkg::OP_REQ_RDMA,
         umi_pkg::OP_RESP_WRITE,
         umi_pkg::OP_REQ_USER0,
         umi_pkg::OP_REQ_FUTURE0:
            pkt_bytes = lumi_pkg::LINES_W'(umi_pkg::HDR_BYTES);
         default:                               // Header plus used data
            pkt_bytes = lumi_pkg::LINES_W'(umi_pkg::HDR_BYTES) +
                        data_cap[lumi_pkg::LINES_W-1:0];
      endcase
   end

   // Low bytes of the shift register that go out, lsb first
   assign pkt_mask = ~({umi_pkg::PB{1'b1}} << pkt_bytes);

   // Round up to whole lines
   assign pkt_lines = (pkt_bytes + ((lumi_pkg::LINES_W'(1) << iowidth) - 1'b1)) >> iowidth;
   assign crdt_need = lumi_pkg::crdt_t'(pkt_lines);

endmodule

// ==== lumi_tx_credit.sv ====
// Transmit credit tracking
`timescale 1ns/1ps

module lumi_tx_credit
  (
   input  logic               clk,
   input  logic               nreset,
   input  logic               tx_en,
   input  logic               crdt_en,
   input  lumi_pkg::crdt_t    crdt_intrvl,
   input  lumi_pkg::crdt_t    req_need,
   input  lumi_pkg::crdt_t    resp_need,
   input  lumi_pkg::crdt_t    rmt_crdt_req,
   input  lumi_pkg::crdt_t    rmt_crdt_resp,
   input  logic [1:0]         rmt_crdt_init,
   input  lumi_pkg::crdt_t    loc_crdt_req,
   input  lumi_pkg::crdt_t    loc_crdt_resp,
   input  logic [1:0]         loc_crdt_init,
   input  logic               sent_line,
   input  logic [1:0]         sent_type,    // {resp, req}
   input  logic               accept_updt,
   output logic               req_ok,
   output logic               resp_ok,
   output logic               updt_pending,
   output umi_pkg::umi_cmd_t  updt_cmd
   );

   lumi_pkg::crdt_t  tx_req;
   lumi_pkg::crdt_t  tx_resp;
   lumi_pkg::crdt_t  req_avail;
   lumi_pkg::crdt_t  resp_avail;
   lumi_pkg::crdt_t  updt_cnt;
   lumi_pkg::crdt_t  msg_crdt;
   logic             updt_hit;
   logic [1:0]       updt_send;     // Bit 0 resp message, bit 1 req message
   logic [3:0]       msg_ch;
   logic [3:0]       msg_code;

   // ################################################
   // Transmitted line counters
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         tx_req <= '0;
         tx_resp <= '0;
      end
      else if (!tx_en)
      begin
         tx_req <= '0;
         tx_resp <= '0;
      end
      else if (sent_line)
      begin
         tx_req <= tx_req + lumi_pkg::crdt_t'(sent_type[0]);
         tx_resp <= tx_resp + lumi_pkg::crdt_t'(sent_type[1]);
      end
   end

   // Less a line leaving in this cycle
   assign req_avail = rmt_crdt_req - tx_req - lumi_pkg::crdt_t'(sent_line & sent_type[0]);
   assign resp_avail = rmt_crdt_resp - tx_resp - lumi_pkg::crdt_t'(sent_line & sent_type[1]);

   // Infinite credit when off, nothing until remote init ends
   assign req_ok = ~crdt_en | (~|rmt_crdt_init & (req_avail >= req_need));
   assign resp_ok = ~crdt_en | (~|rmt_crdt_init & (resp_avail >= resp_need));

   // ################################################
   // Credit message timer
   // ################################################
   assign updt_hit = crdt_en & (updt_cnt == crdt_intrvl);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         updt_cnt <= '0;
      else if (!crdt_en || updt_hit)
         updt_cnt <= '0;
      else
         updt_cnt <= updt_cnt + 1'b1;
   end

   // Resp message first, req after it
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         updt_send <= 2'b00;
      else if (updt_hit)
         updt_send <= 2'b01;
      else if (accept_updt)
         updt_send <= updt_send << 1;
   end

   assign updt_pending = |updt_send;

   assign msg_ch = updt_send[0] ? lumi_pkg::CH_RESP : lumi_pkg::CH_REQ;
   assign msg_crdt = updt_send[0] ? loc_crdt_resp : loc_crdt_req;
   assign msg_code = (updt_send[0] ? loc_crdt_init[1] : loc_crdt_init[0]) ?
                     lumi_pkg::MSG_INIT : lumi_pkg::MSG_UPDT;
   assign updt_cmd = {msg_crdt, msg_ch, msg_code, umi_pkg::LINK_LOW};

   // Serializer gating keeps the link within remote credit
   a_within_credit: assert property (@(posedge clk) disable iff (!nreset || !tx_en)
      crdt_en |-> (tx_req <= rmt_crdt_req) && (tx_resp <= rmt_crdt_resp));

endmodule

// ==== lumi_tx_serializer.sv ====
// Packet arbiter and output shift register
`timescale 1ns/1ps

module lumi_tx_serializer
  (
   input  logic                          clk,
   input  logic                          nreset,
   input  logic                          tx_en,
   input  logic [lumi_pkg::LOG_W-1:0]    iowidth,
   input  logic                          umi_req_in_valid,
   input  umi_pkg::umi_cmd_t             umi_req_in_cmd,
   input  logic [umi_pkg::AW-1:0]        umi_req_in_dstaddr,
   input  logic [umi_pkg::AW-1:0]        umi_req_in_srcaddr,
   input  logic [umi_pkg::DW-1:0]        umi_req_in_data,
   input  logic                          umi_resp_in_valid,
   input  umi_pkg::umi_cmd_t             umi_resp_in_cmd,
   input  logic [umi_pkg::AW-1:0]        umi_resp_in_dstaddr,
   input  logic [umi_pkg::AW-1:0]        umi_resp_in_srcaddr,
   input  logic [umi_pkg::DW-1:0]        umi_resp_in_data,
   input  logic                          req_ok,
   input  logic                          resp_ok,
   input  lumi_pkg::mask_t               req_mask,
   input  lumi_pkg::mask_t               resp_mask,
   input  logic                          updt_pending,
   input  umi_pkg::umi_cmd_t             updt_cmd,
   input  logic                          phy_txrdy,
   output logic                          umi_req_in_ready,
   output logic                          umi_resp_in_ready,
   output logic                          accept_updt,
   output logic                          sent_line,
   output logic [1:0]                    sent_type,
   output logic [lumi_pkg::IOW-1:0]      phy_txdata,
   output logic                          phy_txvld
   );

   logic [umi_pkg::PW-1:0]            shiftreg;
   logic [umi_pkg::PW-1:0]            load_data;
   lumi_pkg::mask_t                   mask;
   lumi_pkg::mask_t                   mask_next;
   lumi_pkg::mask_t                   load_mask;
   logic [$clog2(lumi_pkg::IOB):0]    line_bytes;
   logic [1:0]                        ld_type;      // {resp, req}
   logic                              idle;
   logic                              resp_go;
   logic                              req_go;
   logic                              load;

   assign line_bytes = 1'b1 << iowidth;
   assign mask_next = mask >> line_bytes;

   // ################################################
   // Arbitration
   // ################################################
   // Free when empty or the last line leaves now
   assign idle = tx_en & (~|mask | ~|mask_next);

   // Credit messages hold off both channels
   assign resp_go = umi_resp_in_valid & resp_ok & ~updt_pending;
   assign req_go = umi_req_in_valid & req_ok & ~updt_pending;

   assign load = idle & phy_txrdy & (updt_pending | resp_go | req_go);
   assign accept_updt = idle & phy_txrdy & updt_pending;
   assign umi_resp_in_ready = idle & phy_txrdy & resp_go;
   assign umi_req_in_ready = idle & phy_txrdy & req_go & ~resp_go;    // Resp wins

   always_comb
   begin
      if (updt_pending)
      begin
         load_data = {{(umi_pkg::PW - umi_pkg::CW){1'b0}}, updt_cmd};
         load_mask = ~({umi_pkg::PB{1'b1}} << umi_pkg::CMD_BYTES);
      end
      else if (resp_go)
      begin
         load_data = {umi_resp_in_data, umi_resp_in_srcaddr, umi_resp_in_dstaddr,
                      umi_resp_in_cmd};
         load_mask = resp_mask;
      end
      else
      begin
         load_data = {umi_req_in_data, umi_req_in_srcaddr, umi_req_in_dstaddr,
                      umi_req_in_cmd};
         load_mask = req_mask;
      end
   end

   // ################################################
   // Shift register, lsb byte first
   // ################################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         mask <= '0;
         ld_type <= 2'b00;
      end
      else if (load)
      begin
         mask <= load_mask;
         ld_type <= {resp_go, req_go & ~resp_go};    // Messages count as neither
      end
      else if (phy_txrdy)
         mask <= mask_next;                           // Stalled phy freezes all
   end

   always_ff @(posedge clk)
   begin
      if (load)
         shiftreg <= load_data;
      else if (phy_txrdy & phy_txvld)
         shiftreg <= shiftreg >> {line_bytes, 3'b000};
   end

   assign phy_txvld = |mask;
   assign phy_txdata = shiftreg[lumi_pkg::IOW-1:0];
   assign sent_line = phy_txvld & phy_txrdy;
   assign sent_type = ld_type;

   a_one_ready: assert property (@(posedge clk) disable iff (!nreset)
      !(umi_req_in_ready && umi_resp_in_ready));

   // Accepted packet is on the line next cycle
   a_load_sends: assert property (@(posedge clk) disable iff (!nreset)
      load |=> phy_txvld);

endmodule

// ==== lumi_tx.sv ====
// Link transmit top level
`timescale 1ns/1ps

module lumi_tx
  (
   input  logic                          clk,
   input  logic                          nreset,
   // Configuration port
   input  logic                          cfg_req,
   input  logic [lumi_pkg::CFG_AW-1:0]   cfg_addr,
   input  logic [lumi_pkg::CFG_DW-1:0]   cfg_wdata,
   output logic                          cfg_ack,
   // Request channel
   input  logic                          umi_req_in_valid,
   input  umi_pkg::umi_cmd_t             umi_req_in_cmd,
   input  logic [umi_pkg::AW-1:0]        umi_req_in_dstaddr,
   input  logic [umi_pkg::AW-1:0]        umi_req_in_srcaddr,
   input  logic [umi_pkg::DW-1:0]        umi_req_in_data,
   output logic                          umi_req_in_ready,
   // Response channel
   input  logic                          umi_resp_in_valid,
   input  umi_pkg::umi_cmd_t             umi_resp_in_cmd,
   input  logic [umi_pkg::AW-1:0]        umi_resp_in_dstaddr,
   input  logic [umi_pkg::AW-1:0]        umi_resp_in_srcaddr,
   input  logic [umi_pkg::DW-1:0]        umi_resp_in_data,
   output logic                          umi_resp_in_ready,
   // Phy
   output logic [lumi_pkg::IOW-1:0]      phy_txdata,
   output logic                          phy_txvld,
   input  logic                          phy_txrdy,
   // Credits
   input  lumi_pkg::crdt_t               rmt_crdt_req,
   input  lumi_pkg::crdt_t               rmt_crdt_resp,
   input  lumi_pkg::crdt_t               loc_crdt_req,
   input  lumi_pkg::crdt_t               loc_crdt_resp,
   input  logic [1:0]                    loc_crdt_init,
   input  logic [1:0]                    rmt_crdt_init
   );

   logic                          tx_en;
   logic                          crdt_en;
   logic [lumi_pkg::LOG_W-1:0]    iowidth;
   lumi_pkg::crdt_t               crdt_intrvl;
   lumi_pkg::mask_t               req_mask;
   lumi_pkg::mask_t               resp_mask;
   lumi_pkg::crdt_t               req_need;
   lumi_pkg::crdt_t               resp_need;
   logic                          req_ok;
   logic                          resp_ok;
   logic                          updt_pending;
   umi_pkg::umi_cmd_t             updt_cmd;
   logic                          accept_updt;
   logic                          sent_line;
   logic [1:0]                    sent_type;

   lumi_tx_cfg cfg0 (.clk, .nreset, .cfg_req, .cfg_addr, .cfg_wdata, .cfg_ack,
                     .tx_en, .crdt_en, .iowidth, .crdt_intrvl);

   // One sizer per channel
   lumi_tx_sizer sizer_req (.cmd(umi_req_in_cmd), .iowidth,
                            .pkt_mask(req_mask), .crdt_need(req_need));
   lumi_tx_sizer sizer_resp (.cmd(umi_resp_in_cmd), .iowidth,
                             .pkt_mask(resp_mask), .crdt_need(resp_need));

   lumi_tx_credit credit0 (.clk, .nreset, .tx_en, .crdt_en, .crdt_intrvl,
                           .req_need, .resp_need, .rmt_crdt_req, .rmt_crdt_resp,
                           .rmt_crdt_init, .loc_crdt_req, .loc_crdt_resp, .loc_crdt_init,
                           .sent_line, .sent_type, .accept_updt,
                           .req_ok, .resp_ok, .updt_pending, .updt_cmd);

   lumi_tx_serializer ser0 (.clk, .nreset, .tx_en, .iowidth,
                            .umi_req_in_valid, .umi_req_in_cmd, .umi_req_in_dstaddr,
                            .umi_req_in_srcaddr, .umi_req_in_data,
                            .umi_resp_in_valid, .umi_resp_in_cmd, .umi_resp_in_dstaddr,
                            .umi_resp_in_srcaddr, .umi_resp_in_data,
                            .req_ok, .resp_ok, .req_mask, .resp_mask,
                            .updt_pending, .updt_cmd, .phy_txrdy,
                            .umi_req_in_ready, .umi_resp_in_ready, .accept_updt,
                            .sent_line, .sent_type, .phy_txdata, .phy_txvld);

endmodule

// ==== lumi_tx_tb.sv ====
// Link transmit testbench
`timescale 1ns/1ps

module lumi_tx_tb;

   localparam int TIMEOUT = 2000;               // Cycles allowed per wait

   logic                          clk;
   logic                          nreset;
   logic                          cfg_req;
   logic [lumi_pkg::CFG_AW-1:0]   cfg_addr;
   logic [lumi_pkg::CFG_DW-1:0]   cfg_wdata;
   logic                          cfg_ack;
   logic                          umi_req_in_valid;
   umi_pkg::umi_cmd_t             umi_req_in_cmd;
   logic [umi_pkg::AW-1:0]        umi_req_in_dstaddr;
   logic [umi_pkg::AW-1:0]        umi_req_in_srcaddr;
   logic [umi_pkg::DW-1:0]        umi_req_in_data;
   logic                          umi_req_in_ready;
   logic                          umi_resp_in_valid;
   umi_pkg::umi_cmd_t             umi_resp_in_cmd;
   logic [umi_pkg::AW-1:0]        umi_resp_in_dstaddr;
   logic [umi_pkg::AW-1:0]        umi_resp_in_srcaddr;
   logic [umi_pkg::DW-1:0]        umi_resp_in_data;
   logic                          umi_resp_in_ready;
   logic [lumi_pkg::IOW-1:0]      phy_txdata;
   logic                          phy_txvld;
   logic                          phy_txrdy;
   lumi_pkg::crdt_t               rmt_crdt_req;
   lumi_pkg::crdt_t               rmt_crdt_resp;
   lumi_pkg::crdt_t               loc_crdt_req;
   lumi_pkg::crdt_t               loc_crdt_resp;
   logic [1:0]                    loc_crdt_init;
   logic [1:0]                    rmt_crdt_init;

   int                            errors;
   int                            pkts_done;   // Packets fully seen on the phy
   int                            lines_seen;
   int                            byte_off;    // Position inside current packet
   logic [1:0]                    cur_iow;     // Line width code in use
   logic                          stall_en;
   logic                          credit_hold; // Request must stay blocked
   logic [7:0]                    exp_bytes[$];
   int                            exp_len[$];

   lumi_tx dut0 (.*);

   always #10 clk = ~clk;

   // Random phy back pressure, about one stall in four
   always @(posedge clk)
      phy_txrdy <= stall_en ? ($urandom % 4 != 0) : 1'b1;

   // Source side drops valid once the packet is taken
   always @(posedge clk)
   begin
      if (umi_req_in_valid && umi_req_in_ready)
         umi_req_in_valid <= 1'b0;
      if (umi_resp_in_valid && umi_resp_in_ready)
         umi_resp_in_valid <= 1'b0;
   end

   task automatic count_error(input string msg);
      errors++;
      $display("Error %0t: %s", $time, msg);
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timeout waiting for %s, errors %0d", what, errors);
      $display("*** FAILED ***");
      $finish;
   endtask

   // Bytes on the link for one command
   function automatic int packet_bytes(input umi_pkg::umi_cmd_t cmd);
      logic [4:0] op;
      int data_n;
      op = cmd[4:0];
      data_n = (int'(cmd[15:8]) + 1) << cmd[7:5];
      if (data_n > 16)
         data_n = 16;                           // Data field holds 16 bytes
      if (op == umi_pkg::OP_INVALID || op == umi_pkg::OP_RESP_LINK ||
          cmd[7:0] == umi_pkg::LINK_LOW)
         return umi_pkg::CMD_BYTES;
      if (op inside {umi_pkg::OP_REQ_READ, umi_pkg::OP_REQ_RDMA, umi_pkg::OP_REQ_ERROR,
                     umi_pkg::OP_RESP_WRITE, umi_pkg::OP_REQ_USER0, umi_pkg::OP_REQ_FUTURE0})
         return umi_pkg::HDR_BYTES;
      return umi_pkg::HDR_BYTES + data_n;
   endfunction

   function automatic umi_pkg::umi_cmd_t rand_write();
      return {16'h0000, 8'($urandom % 16), 3'($urandom % 3), umi_pkg::OP_REQ_WRITE};
   endfunction

   // ################################################
   // Scoreboard
   // ################################################
   task automatic expect_packet(input umi_pkg::umi_cmd_t cmd,
                                input logic [umi_pkg::AW-1:0] dst,
                                input logic [umi_pkg::AW-1:0] src,
                                input logic [umi_pkg::DW-1:0] data);
      logic [umi_pkg::PW-1:0] pkt;
      int n;
      int i;
      pkt = {data, src, dst, cmd};              // Byte 0 is the low cmd byte
      n = packet_bytes(cmd);
      for (i = 0; i < n; i++)
         exp_bytes.push_back(pkt[8*i +: 8]);
      exp_len.push_back(n);
   endtask

   always @(posedge clk)
   begin : monitor
      int lb;
      int i;
      logic [7:0] want;
      if (nreset && phy_txvld && phy_txrdy)
      begin
         lb = 1 << cur_iow;
         lines_seen++;
         assert (exp_len.size() != 0) else
            count_error("line sent with no packet expected");
         if (exp_len.size() != 0)
         begin
            for (i = 0; i < lb; i++)
            begin
               if (byte_off < exp_len[0])      // Tail of last line is don't care
               begin
                  want = exp_bytes.pop_front();
                  assert (phy_txdata[8*i +: 8] == want) else
                     count_error($sformatf("byte %0d got %h expected %h",
                                           byte_off, phy_txdata[8*i +: 8], want));
                  byte_off++;
               end
            end
            if (byte_off >= exp_len[0])
            begin
               void'(exp_len.pop_front());
               byte_off = 0;
               pkts_done++;
            end
         end
      end
   end

   // ################################################
   // Protocol checks
   // ################################################
   a_ack_rise: assert property (@(posedge clk) disable iff (!nreset)
      cfg_req && !cfg_ack |=> cfg_ack) else count_error("cfg_ack did not follow req");
   a_ack_fall: assert property (@(posedge clk) disable iff (!nreset)
      !cfg_req && cfg_ack |=> !cfg_ack) else count_error("cfg_ack stuck after req fell");
   a_ready_valid: assert property (@(posedge clk) disable iff (!nreset)
      !(umi_req_in_ready && !umi_req_in_valid) && !(umi_resp_in_ready && !umi_resp_in_valid))
      else count_error("ready without valid");
   a_stall_hold: assert property (@(posedge clk) disable iff (!nreset)
      phy_txvld && !phy_txrdy |=> phy_txvld && $stable(phy_txdata))
      else count_error("line changed under a phy stall");
   a_credit_block: assert property (@(posedge clk) disable iff (!nreset)
      credit_hold |-> !umi_req_in_ready) else count_error("request taken without credit");

   // Four phase register write
   task automatic cfg_write(input logic [lumi_pkg::CFG_AW-1:0] addr,
                            input logic [lumi_pkg::CFG_DW-1:0] data);
      int n;
      @(posedge clk);
      cfg_req <= 1'b1;
      cfg_addr <= addr;
      cfg_wdata <= data;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end while (!cfg_ack && n < 20);
      if (!cfg_ack)
         stop_on_timeout("cfg_ack to rise");
      cfg_req <= 1'b0;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
      end while (cfg_ack && n < 20);
      if (cfg_ack)
         stop_on_timeout("cfg_ack to fall");
   endtask

   task automatic set_ctrl(input logic en, input logic crdt, input logic [1:0] iow);
      logic [lumi_pkg::CFG_DW-1:0] w;
      w = '0;
      w[lumi_pkg::CTRL_EN_BIT] = en;
      w[lumi_pkg::CTRL_CRDT_BIT] = crdt;
      w[lumi_pkg::CTRL_IOW_LSB +: 2] = iow;
      cfg_write(lumi_pkg::CFG_CTRL, w);
      cur_iow = iow;                            // Link is idle here
   endtask

   // Drive one packet with random addresses and data
   task automatic drive_pkt(input logic resp, input umi_pkg::umi_cmd_t cmd);
      logic [umi_pkg::AW-1:0] dst;
      logic [umi_pkg::AW-1:0] src;
      logic [umi_pkg::DW-1:0] data;
      dst = {$urandom, $urandom};
      src = {$urandom, $urandom};
      data = {$urandom, $urandom, $urandom, $urandom};
      expect_packet(cmd, dst, src, data);
      if (resp)
      begin
         umi_resp_in_valid <= 1'b1;
         umi_resp_in_cmd <= cmd;
         umi_resp_in_dstaddr <= dst;
         umi_resp_in_srcaddr <= src;
         umi_resp_in_data <= data;
      end
      else
      begin
         umi_req_in_valid <= 1'b1;
         umi_req_in_cmd <= cmd;
         umi_req_in_dstaddr <= dst;
         umi_req_in_srcaddr <= src;
         umi_req_in_data <= data;
      end
   endtask

   task automatic wait_accept();
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end while ((umi_req_in_valid || umi_resp_in_valid) && n < TIMEOUT);
      if (umi_req_in_valid || umi_resp_in_valid)
         stop_on_timeout("packet acceptance");
   endtask

   task automatic wait_pkts(input int target);
      int n;
      n = 0;
      do
      begin
         @(negedge clk);
         n++;
      end while (pkts_done < target && n < TIMEOUT);
      if (pkts_done < target)
         stop_on_timeout("packets on the phy");
   endtask

   // Trailing lines of the packet still count
   task automatic wait_idle();
      int n;
      n = 0;
      while (phy_txvld && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (phy_txvld)
         stop_on_timeout("phy to go idle");
   endtask

   // One packet, then its line count
   task automatic send_pkt(input logic resp, input umi_pkg::umi_cmd_t cmd);
      int first_line;
      int target;
      int lb;
      first_line = lines_seen;
      target = pkts_done + 1;
      lb = 1 << cur_iow;
      @(posedge clk);
      drive_pkt(resp, cmd);
      wait_accept();
      wait_pkts(target);
      wait_idle();
      assert (lines_seen - first_line == (packet_bytes(cmd) + lb - 1) / lb) else
         count_error($sformatf("cmd %h took %0d lines", cmd, lines_seen - first_line));
   endtask

   // ################################################
   // Test sequence
   // ################################################
   initial
   begin : main
      int target;
      void'($urandom(17733));
      clk = 1'b0;
      nreset = 1'b0;
      cfg_req = 1'b0;
      cfg_addr = '0;
      cfg_wdata = '0;
      umi_req_in_valid = 1'b0;
      umi_req_in_cmd = '0;
      umi_req_in_dstaddr = '0;
      umi_req_in_srcaddr = '0;
      umi_req_in_data = '0;
      umi_resp_in_valid = 1'b0;
      umi_resp_in_cmd = '0;
      umi_resp_in_dstaddr = '0;
      umi_resp_in_srcaddr = '0;
      umi_resp_in_data = '0;
      phy_txrdy = 1'b0;
      rmt_crdt_req = 16'h0100;
      rmt_crdt_resp = 16'h0100;
      loc_crdt_req = 16'h1234;
      loc_crdt_resp = 16'h5678;
      loc_crdt_init = 2'b00;
      rmt_crdt_init = 2'b00;                    // Remote init already done
      errors = 0;
      pkts_done = 0;
      lines_seen = 0;
      byte_off = 0;
      cur_iow = 2'd3;
      stall_en = 1'b0;
      credit_hold = 1'b0;
      repeat (8) @(posedge clk);
      nreset <= 1'b1;
      @(negedge clk);
      assert (!phy_txvld && !umi_req_in_ready && !umi_resp_in_ready && !cfg_ack) else
         count_error("outputs active after reset");

      // Writes at 8 and 2 byte lines under stalls
      stall_en = 1'b1;
      set_ctrl(1'b1, 1'b0, 2'd3);
      send_pkt(1'b0, {16'h0000, 8'd15, 3'd0, umi_pkg::OP_REQ_WRITE});   // Full 36 bytes
      repeat (4) send_pkt(1'b0, rand_write());
      set_ctrl(1'b1, 1'b0, 2'd1);
      repeat (4) send_pkt(1'b0, rand_write());

      // Header only and command only packets
      set_ctrl(1'b1, 1'b0, 2'd2);
      send_pkt(1'b0, {16'h0000, 8'h03, 3'd2, umi_pkg::OP_REQ_READ});
      send_pkt(1'b0, {16'h00ab, 8'h00, umi_pkg::LINK_LOW});
      send_pkt(1'b1, {16'h0000, 8'h00, 3'd0, umi_pkg::OP_RESP_WRITE});

      // Both channels in one cycle, response goes first
      set_ctrl(1'b1, 1'b0, 2'd3);
      target = pkts_done + 2;
      @(posedge clk);
      drive_pkt(1'b1, {16'h0000, 8'd1, 3'd2, umi_pkg::OP_RESP_READ});
      drive_pkt(1'b0, rand_write());
      wait_accept();
      wait_pkts(target);

      // Request held back by remote credit
      set_ctrl(1'b0, 1'b0, 2'd3);               // Clears line counters
      cfg_write(lumi_pkg::CFG_INTRVL, 16'hffff);
      rmt_crdt_req <= 16'd4;                    // One line short
      set_ctrl(1'b1, 1'b1, 2'd3);
      target = pkts_done + 1;
      @(posedge clk);
      drive_pkt(1'b0, {16'h0000, 8'd15, 3'd0, umi_pkg::OP_REQ_WRITE});
      credit_hold <= 1'b1;
      repeat (200) @(posedge clk);
      assert (umi_req_in_valid) else
         count_error("request left without credit");
      credit_hold <= 1'b0;
      rmt_crdt_req <= 16'd5;
      wait_accept();
      wait_pkts(target);

      // Credit messages on a short interval
      set_ctrl(1'b1, 1'b0, 2'd3);
      cfg_write(lumi_pkg::CFG_INTRVL, 16'd40);
      expect_packet({loc_crdt_resp, lumi_pkg::CH_RESP, lumi_pkg::MSG_UPDT, umi_pkg::LINK_LOW},
                    '0, '0, '0);
      expect_packet({loc_crdt_req, lumi_pkg::CH_REQ, lumi_pkg::MSG_UPDT, umi_pkg::LINK_LOW},
                    '0, '0, '0);
      target = pkts_done + 2;
      set_ctrl(1'b1, 1'b1, 2'd3);
      wait_pkts(target);
      set_ctrl(1'b1, 1'b0, 2'd3);               // Before the next interval

      stall_en = 1'b0;
      repeat (10) @(posedge clk);               // Room for a stray line
      $display("Packets %0d, lines %0d, errors %0d", pkts_done, lines_seen, errors);
      if (errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== lumi_tx.f ====
umi_pkg.sv
lumi_pkg.sv
lumi_tx_cfg.sv
lumi_tx_sizer.sv
lumi_tx_credit.sv
lumi_tx_serializer.sv
lumi_tx.sv
lumi_tx_tb.sv

// ==== Bender.yml ====
package:
  name: lumi_tx

sources:
  # Packages first
  - umi_pkg.sv
  - lumi_pkg.sv
  # Design
  - lumi_tx_cfg.sv
  - lumi_tx_sizer.sv
  - lumi_tx_credit.sv
  - lumi_tx_serializer.sv
  - lumi_tx.sv
  # Testbench
  - target: test
    files:
      - lumi_tx_tb.sv
